//--- compile.f
+incdir+src
src/i2c_pkg.sv
src/i2c_bit_ctrl.sv
src/i2c_byte_ctrl.sv
src/i2c_master_wbs_8.sv
src/i2c_main_controller.sv
src/i2c.sv
tb/i2c_slave_model.sv
tb/tb_i2c.sv

//--- tb/tb_i2c.sv
`include "i2c_config.svh"

module tb_i2c;

	localparam logic [6:0] slave_addr = 7'h3a;
	localparam logic [7:0] reg_init   = 8'ha5;

	logic        clk;
	logic        nrst;
	logic [31:0] memory_data;
	logic [31:0] memory_control;
	logic        scl_t;
	logic        sda_t;
	logic        scl_hold;
	logic        sda_hold;
	logic        scl_bus;
	logic        sda_bus;
	logic [31:0] rd_data;
	logic [31:0] status;
	logic [7:0]  slave_reg;
	logic [31:0] start_cnt;
	logic [31:0] stop_cnt;
	logic [31:0] xfer_cnt;
	logic        master_nack;
	int          cycles = 0;
	int          pass_cnt = 0;
	int          fail_cnt = 0;
	int          test_err = 0;
	logic [7:0]  exp_reg;       // Reference copy of the slave register
	logic [31:0] exp_rd;        // Reference rd_data_o
	logic [7:0]  exp_log [$];   // Bytes the slave should have moved
	logic [6:0]  addr;
	logic [7:0]  data;
	logic        rnw;
	logic [31:0] stops;

	// Wired-AND buses with pull-ups
	assign scl_bus = scl_t & ~scl_hold;
	assign sda_bus = sda_t & ~sda_hold;

	initial clk = 1'b0;
	always #50 clk = ~clk;

	i2c dut0 (
		.clk              (clk),
		.nrst             (nrst),
		.memory_data_i    (memory_data),
		.memory_control_i (memory_control),
		.i2c_scl_i        (scl_bus),
		.i2c_sda_i        (sda_bus),
		.i2c_scl_t_o      (scl_t),
		.i2c_sda_t_o      (sda_t),
		.rd_data_o        (rd_data),
		.status_o         (status)
	);

	i2c_slave_model #(.slave_addr(slave_addr), .reg_init(reg_init)) slave0 (
		.clk           (clk),
		.nrst          (nrst),
		.scl_i         (scl_bus),
		.sda_i         (sda_bus),
		.scl_hold_o    (scl_hold),
		.sda_hold_o    (sda_hold),
		.reg_o         (slave_reg),
		.start_cnt_o   (start_cnt),
		.stop_cnt_o    (stop_cnt),
		.master_nack_o (master_nack),
		.xfer_cnt_o    (xfer_cnt)
	);

	// Run limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= `I2C_TIMEOUT_CYCLES) begin
			$display("Timeout: run stopped after %0d cycles without finishing", cycles);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	task compare_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("Fail %s: got %h, expected %h", name, got, exp);
			fail_cnt++;
			test_err++;
		end else begin
			pass_cnt++;
		end
	endtask

	task report_error(input string msg);
		$display("Error: %s", msg);
		fail_cnt++;
		test_err++;
	endtask

	task close_test(input string name);
		$display("Test %s finished with %0d errors", name, test_err);
		test_err = 0;
	endtask

	// One host request where extra_go adds a second go edge mid-transfer
	task run_request(input logic [6:0] a, input logic r, input logic [7:0] d,
		input logic extra_go);
		logic [31:0] starts;
		logic        busy_lost;
		starts    = start_cnt;
		busy_lost = 1'b0;
		@(posedge clk);
		memory_control <= {23'd0, a, r, 1'b1};
		memory_data    <= {24'd0, d};
		@(posedge clk);
		@(negedge clk);
		if (status[0] !== 1'b1)
			report_error("busy did not rise in the cycle after the go edge");
		if (extra_go) begin
			@(posedge clk);
			memory_control[0] <= 1'b0;
			repeat (3) @(posedge clk);
			memory_control[0] <= 1'b1; // Must be ignored while busy
		end
		@(negedge clk);
		while (status[1] !== 1'b1) begin
			if (status[0] !== 1'b1 && !busy_lost) begin
				report_error("busy dropped before done was set");
				busy_lost = 1'b1;
			end
			@(negedge clk);
		end
		compare_hex("status_o busy", status[0], 32'd0);
		compare_hex("slave start count", start_cnt - starts, 32'd1);
		@(posedge clk);
		memory_control[0] <= 1'b0;
		@(negedge clk);
	endtask

	initial begin
		void'($urandom(36));
		nrst           = 1'b0;
		memory_control = 32'd0;
		memory_data    = 32'd0;
		exp_reg        = reg_init;
		exp_rd         = 32'd0;
		repeat (8) @(posedge clk);
		nrst <= 1'b1;
		@(negedge clk);

		compare_hex("status_o", status, 32'd0);
		compare_hex("rd_data_o", rd_data, 32'd0);
		compare_hex("release outputs", {scl_t, sda_t}, 32'd3);
		compare_hex("slave start count", start_cnt, 32'd0);
		while (dut0.core0.ena !== 1'b1) // Controller finishes core setup
			@(negedge clk);
		close_test("reset");

		for (int i = 0; i < 20; i++) begin
			data = 8'($urandom_range(255));
			run_request(slave_addr, 1'b0, data, 1'b0);
			exp_reg = data;
			exp_log.push_back(data);
			compare_hex("status_o", status, 32'h2);
			compare_hex("slave register", slave_reg, exp_reg);
		end
		close_test("random writes");

		for (int i = 0; i < 5; i++) begin
			data = 8'($urandom_range(255));
			run_request(slave_addr, 1'b0, data, 1'b0);
			exp_reg = data;
			exp_log.push_back(data);
			run_request(slave_addr, 1'b1, 8'h00, 1'b0);
			exp_rd = {24'd0, exp_reg};
			exp_log.push_back(exp_reg);
			compare_hex("status_o", status, 32'h2);
			compare_hex("rd_data_o", rd_data, exp_rd);
			compare_hex("master nack", master_nack, 32'd1);
		end
		close_test("random reads");

		for (int i = 0; i < 6; i++) begin
			do
				addr = 7'($urandom_range(127));
			while (addr == slave_addr);
			rnw   = 1'($urandom_range(1));
			data  = 8'($urandom_range(255));
			stops = stop_cnt;
			run_request(addr, rnw, data, 1'b0);
			compare_hex("status_o", status, 32'h6); // Nack and done
			compare_hex("slave register", slave_reg, exp_reg);
			compare_hex("rd_data_o", rd_data, exp_rd);
			compare_hex("slave stop count", stop_cnt - stops, 32'd1);
			compare_hex("release outputs", {scl_t, sda_t}, 32'd3);
		end
		close_test("address nack");

		for (int i = 0; i < 3; i++) begin
			data = 8'($urandom_range(255));
			run_request(slave_addr, 1'b0, data, 1'b1);
			exp_reg = data;
			exp_log.push_back(data);
			compare_hex("status_o", status, 32'h2);
			compare_hex("slave register", slave_reg, exp_reg);
		end
		close_test("ignored go");

		compare_hex("slave byte count", xfer_cnt, exp_log.size());
		for (int i = 0; i < exp_log.size(); i++)
			compare_hex("slave byte log", slave0.log_mem[i], exp_log[i]);
		close_test("stretch byte log");

		$display("Checks passed %0d, failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

//--- tb/i2c_slave_model.sv
`include "i2c_config.svh"

module i2c_slave_model #(
	parameter logic [6:0] slave_addr = 7'h3a,
	parameter logic [7:0] reg_init   = 8'ha5
) (
	input  logic        clk,
	input  logic        nrst,
	input  logic        scl_i,
	input  logic        sda_i,
	output logic        scl_hold_o,    // 1 pulls SCL low
	output logic        sda_hold_o,    // 1 pulls SDA low
	output logic [7:0]  reg_o,         // The one storage register
	output logic [31:0] start_cnt_o,
	output logic [31:0] stop_cnt_o,
	output logic        master_nack_o, // Level seen in the master's ack slot
	output logic [31:0] xfer_cnt_o     // Data bytes moved either way
);

	localparam int quarter = `I2C_PRESCALE + 1;

	logic [7:0] log_mem [0:63]; // Every data byte moved, in order
	logic       scl_q;
	logic       sda_q;
	logic       active;         // Between START and STOP
	logic       addressed;
	logic       rnw;
	logic [3:0] bits;           // Rising edges in the current byte, 9 with ack
	logic [1:0] byte_cnt;       // 0 is the address byte
	logic [7:0] shift;
	int         stretch;

	always @(posedge clk) begin
		if (!nrst) begin
			scl_q         <= 1'b1;
			sda_q         <= 1'b1;
			scl_hold_o    <= 1'b0;
			sda_hold_o    <= 1'b0;
			reg_o         <= reg_init;
			start_cnt_o   <= 32'd0;
			stop_cnt_o    <= 32'd0;
			master_nack_o <= 1'b0;
			xfer_cnt_o    <= 32'd0;
			active        <= 1'b0;
			addressed     <= 1'b0;
			rnw           <= 1'b0;
			bits          <= 4'd0;
			byte_cnt      <= 2'd0;
			shift         <= 8'd0;
			stretch       <= 0;
		end else begin
			scl_q <= scl_i;
			sda_q <= sda_i;
			if (stretch != 0)
				stretch <= stretch - 1;
			scl_hold_o <= (stretch > 1); // Let go once the count runs out
			if (scl_i && scl_q && sda_q && !sda_i) begin
				active        <= 1'b1; // START
				addressed     <= 1'b0;
				bits          <= 4'd0;
				byte_cnt      <= 2'd0;
				master_nack_o <= 1'b0;
				start_cnt_o   <= start_cnt_o + 32'd1;
			end else if (scl_i && scl_q && !sda_q && sda_i) begin
				active     <= 1'b0;    // STOP
				sda_hold_o <= 1'b0;
				stop_cnt_o <= stop_cnt_o + 32'd1;
			end else if (active && scl_i && !scl_q) begin
				bits <= bits + 4'd1;
				if (bits < 4'd8)
					shift <= {shift[6:0], sda_i}; // MSB first
				else if (byte_cnt == 2'd1 && addressed && rnw)
					master_nack_o <= sda_i;
			end else if (active && !scl_i && scl_q) begin : falling
				int unsigned pick;
				pick       = $urandom_range(3);
				stretch    <= pick * quarter; // Hold SCL low 0 to 3 quarter-phases
				scl_hold_o <= (pick != 0);
				case (bits)
					4'd8: begin
						if (byte_cnt == 2'd0) begin
							addressed  <= (shift[7:1] == slave_addr);
							rnw        <= shift[0];
							sda_hold_o <= (shift[7:1] == slave_addr); // Ack own address
						end else if (byte_cnt == 2'd1 && addressed && !rnw) begin
							reg_o                  <= shift;
							log_mem[xfer_cnt_o[5:0]] <= shift;
							xfer_cnt_o             <= xfer_cnt_o + 32'd1;
							sda_hold_o             <= 1'b1;
						end else begin
							sda_hold_o <= 1'b0; // Master owns the ack slot
						end
					end
					4'd9: begin
						bits <= 4'd0;
						if (byte_cnt != 2'd3)
							byte_cnt <= byte_cnt + 2'd1;
						if (byte_cnt == 2'd0 && addressed && rnw) begin
							sda_hold_o             <= ~reg_o[7]; // First read bit
							log_mem[xfer_cnt_o[5:0]] <= reg_o;
							xfer_cnt_o             <= xfer_cnt_o + 32'd1;
						end else begin
							sda_hold_o <= 1'b0;
						end
					end
					default: if (bits != 4'd0 && byte_cnt == 2'd1 && addressed && rnw)
						sda_hold_o <= ~reg_o[3'd7 - bits[2:0]];
				endcase
			end
		end
	end

endmodule

//--- src/i2c.sv
module i2c (
	input  logic        clk,
	input  logic        nrst,
	input  logic [31:0] memory_data_i,
	input  logic [31:0] memory_control_i,
	input  logic        i2c_scl_i,
	input  logic        i2c_sda_i,
	output logic        i2c_scl_t_o, // 1 releases SCL
	output logic        i2c_sda_t_o, // 1 releases SDA
	output logic [31:0] rd_data_o,
	output logic [31:0] status_o
);

	// Internal Wishbone between sequencer and core
	logic [2:0] wb_adr;
	logic [7:0] wb_dat_m2s;
	logic [7:0] wb_dat_s2m;
	logic       wb_we;
	logic       wb_stb;
	logic       wb_cyc;
	logic       wb_ack;

	i2c_main_controller ctrl0 (
		.clk              (clk),
		.nrst             (nrst),
		.memory_control_i (memory_control_i),
		.memory_data_i    (memory_data_i),
		.wbm_adr_o        (wb_adr),
		.wbm_dat_o        (wb_dat_m2s),
		.wbm_dat_i        (wb_dat_s2m),
		.wbm_we_o         (wb_we),
		.wbm_stb_o        (wb_stb),
		.wbm_cyc_o        (wb_cyc),
		.wbm_ack_i        (wb_ack),
		.rd_data_o        (rd_data_o),
		.status_o         (status_o)
	);

	i2c_master_wbs_8 core0 (
		.clk         (clk),
		.nrst        (nrst),
		.wbs_adr_i   (wb_adr),
		.wbs_dat_i   (wb_dat_m2s),
		.wbs_dat_o   (wb_dat_s2m),
		.wbs_we_i    (wb_we),
		.wbs_stb_i   (wb_stb),
		.wbs_cyc_i   (wb_cyc),
		.wbs_ack_o   (wb_ack),
		.i2c_scl_i   (i2c_scl_i),
		.i2c_sda_i   (i2c_sda_i),
		.i2c_scl_t_o (i2c_scl_t_o),
		.i2c_sda_t_o (i2c_sda_t_o)
	);

endmodule

//--- src/i2c_main_controller.sv
`include "i2c_config.svh"

module i2c_main_controller (
	input  logic        clk,
	input  logic        nrst,
	input  logic [31:0] memory_control_i,
	input  logic [31:0] memory_data_i,
	output logic [2:0]  wbm_adr_o,
	output logic [7:0]  wbm_dat_o,
	input  logic [7:0]  wbm_dat_i,
	output logic        wbm_we_o,
	output logic        wbm_stb_o,
	output logic        wbm_cyc_o,
	input  logic        wbm_ack_i,
	output logic [31:0] rd_data_o,
	output logic [31:0] status_o
);

	localparam logic [15:0] prescale_init = `I2C_PRESCALE;

	i2c_pkg::ctrl_state_t state;
	i2c_pkg::cmd_bits_t   cmd;
	i2c_pkg::stat_bits_t  stat;
	logic                 go_q;
	logic                 go_edge;
	logic [6:0]           addr_q;
	logic                 rnw_q;
	logic [7:0]           data_q;
	logic [7:0]           rd_byte;
	logic                 busy;
	logic                 done;
	logic                 nack;

	assign go_edge   = memory_control_i[0] & ~go_q;
	assign stat      = wbm_dat_i; // Valid when a status read is acked
	assign status_o  = {29'd0, nack, done, busy};
	assign rd_data_o = {24'd0, rd_byte};

	// Bus access per state, stable while cyc is up
	always_comb begin
		cmd       = '0;
		wbm_we_o  = 1'b1;
		wbm_adr_o = `I2C_REG_CMD;
		wbm_dat_o = 8'h00;
		case (state)
			i2c_pkg::cs_init_plo: begin
				wbm_adr_o = `I2C_REG_PRE_LO;
				wbm_dat_o = prescale_init[7:0];
			end
			i2c_pkg::cs_init_phi: begin
				wbm_adr_o = `I2C_REG_PRE_HI;
				wbm_dat_o = prescale_init[15:8];
			end
			i2c_pkg::cs_init_ctrl: begin
				wbm_adr_o = `I2C_REG_CTRL;
				wbm_dat_o = 8'h80;              // Enable core
			end
			i2c_pkg::cs_addr_tx: begin
				wbm_adr_o = `I2C_REG_DATA;
				wbm_dat_o = {addr_q, rnw_q};
			end
			i2c_pkg::cs_addr_cmd: begin
				cmd.sta   = 1'b1;
				cmd.wr    = 1'b1;
				wbm_dat_o = cmd;
			end
			i2c_pkg::cs_wr_tx: begin
				wbm_adr_o = `I2C_REG_DATA;
				wbm_dat_o = data_q;
			end
			i2c_pkg::cs_wr_cmd: begin
				cmd.wr    = 1'b1;
				cmd.sto   = 1'b1;
				wbm_dat_o = cmd;
			end
			i2c_pkg::cs_rd_cmd: begin
				cmd.rd    = 1'b1;
				cmd.ack   = 1'b1;                 // NACK the single byte
				cmd.sto   = 1'b1;
				wbm_dat_o = cmd;
			end
			i2c_pkg::cs_nack_stop: begin
				cmd.sto   = 1'b1;
				wbm_dat_o = cmd;
			end
			i2c_pkg::cs_rd_data: begin
				wbm_we_o  = 1'b0;
				wbm_adr_o = `I2C_REG_DATA;
			end
			default: wbm_we_o = 1'b0;           // Status polls
		endcase
	end

	always_ff @(posedge clk) begin
		if (!nrst) begin
			state     <= i2c_pkg::cs_init_plo;
			wbm_cyc_o <= 1'b0;
			wbm_stb_o <= 1'b0;
			go_q      <= 1'b0;
			addr_q    <= 7'd0;
			rnw_q     <= 1'b0;
			data_q    <= 8'd0;
			rd_byte   <= 8'd0;
			busy      <= 1'b0;
			done      <= 1'b0;
			nack      <= 1'b0;
		end else begin
			go_q <= memory_control_i[0];
			if (state == i2c_pkg::cs_idle) begin
				if (go_edge) begin
					addr_q <= memory_control_i[8:2];
					rnw_q  <= memory_control_i[1];
					data_q <= memory_data_i[7:0];
					busy   <= 1'b1;
					done   <= 1'b0;
					nack   <= 1'b0;
					state  <= i2c_pkg::cs_addr_tx;
				end
			end else if (!wbm_cyc_o) begin
				wbm_cyc_o <= 1'b1; // Start next access
				wbm_stb_o <= 1'b1;
			end else if (wbm_ack_i) begin
				wbm_cyc_o <= 1'b0;
				wbm_stb_o <= 1'b0;
				case (state)
					i2c_pkg::cs_init_plo:  state <= i2c_pkg::cs_init_phi;
					i2c_pkg::cs_init_phi:  state <= i2c_pkg::cs_init_ctrl;
					i2c_pkg::cs_init_ctrl: state <= i2c_pkg::cs_idle;
					i2c_pkg::cs_addr_tx:   state <= i2c_pkg::cs_addr_cmd;
					i2c_pkg::cs_addr_cmd:  state <= i2c_pkg::cs_addr_poll;
					i2c_pkg::cs_addr_poll: if (!stat.tip) begin
						if (stat.rxack)
							state <= i2c_pkg::cs_nack_stop; // No slave answered
						else if (rnw_q)
							state <= i2c_pkg::cs_rd_cmd;
						else
							state <= i2c_pkg::cs_wr_tx;
					end
					i2c_pkg::cs_wr_tx:     state <= i2c_pkg::cs_wr_cmd;
					i2c_pkg::cs_wr_cmd:    state <= i2c_pkg::cs_data_poll;
					i2c_pkg::cs_rd_cmd:    state <= i2c_pkg::cs_data_poll;
					i2c_pkg::cs_data_poll: if (!stat.tip) begin
						if (rnw_q) begin
							state <= i2c_pkg::cs_rd_data;
						end else begin
							busy  <= 1'b0;
							done  <= 1'b1;
							state <= i2c_pkg::cs_idle;
						end
					end
					i2c_pkg::cs_rd_data: begin
						rd_byte <= wbm_dat_i;
						busy    <= 1'b0;
						done    <= 1'b1;
						state   <= i2c_pkg::cs_idle;
					end
					i2c_pkg::cs_nack_stop: state <= i2c_pkg::cs_nack_poll;
					i2c_pkg::cs_nack_poll: if (!stat.tip) begin
						nack  <= 1'b1;
						busy  <= 1'b0;
						done  <= 1'b1;
						state <= i2c_pkg::cs_idle;
					end
					default: state <= i2c_pkg::cs_idle;
				endcase
			end
		end
	end

endmodule

//--- src/i2c_master_wbs_8.sv
`include "i2c_config.svh"

module i2c_master_wbs_8 (
	input  logic       clk,
	input  logic       nrst,
	input  logic [2:0] wbs_adr_i,
	input  logic [7:0] wbs_dat_i,
	output logic [7:0] wbs_dat_o,
	input  logic       wbs_we_i,
	input  logic       wbs_stb_i,
	input  logic       wbs_cyc_i,
	output logic       wbs_ack_o,
	input  logic       i2c_scl_i,
	input  logic       i2c_sda_i,
	output logic       i2c_scl_t_o,
	output logic       i2c_sda_t_o
);

	logic [15:0]         prescale;
	logic                ena;      // Core enable, ctrl bit 7
	logic [7:0]          txr;
	logic [7:0]          rxr;
	i2c_pkg::cmd_bits_t  cmd_q;    // Cleared every cycle unless written
	i2c_pkg::stat_bits_t stat;
	logic                acc;      // Access seen, ack goes out next edge
	logic                go;
	logic                tip;
	logic                rxack;
	logic                done;
	logic                bus_busy;
	logic [7:0]          rx_byte;
	logic                rxack_b;

	assign acc = wbs_cyc_i & wbs_stb_i & ~wbs_ack_o;
	assign go  = ena & (cmd_q.sta | cmd_q.sto | cmd_q.rd | cmd_q.wr);

	always_comb begin
		stat       = '0;
		stat.rxack = rxack;
		stat.busy  = bus_busy;
		stat.tip   = tip;
	end

	always_ff @(posedge clk) begin
		if (!nrst) begin
			wbs_ack_o <= 1'b0;
			prescale  <= `I2C_PRESCALE;
			ena       <= 1'b0;
			cmd_q     <= '0;
			tip       <= 1'b0;
			rxack     <= 1'b0;
		end else begin
			wbs_ack_o <= acc; // One cycle after stb
			cmd_q     <= '0;
			if (acc && wbs_we_i) begin
				case (wbs_adr_i)
					`I2C_REG_PRE_LO: prescale[7:0]  <= wbs_dat_i;
					`I2C_REG_PRE_HI: prescale[15:8] <= wbs_dat_i;
					`I2C_REG_CTRL:   ena            <= wbs_dat_i[7];
					`I2C_REG_CMD:    cmd_q          <= wbs_dat_i;
					default: ;
				endcase
			end
			if (done)
				tip <= 1'b0;
			else if (go)
				tip <= 1'b1;
			if (done)
				rxack <= rxack_b;
		end
	end

	// Data path, no reset
	always_ff @(posedge clk) begin
		if (acc && wbs_we_i && wbs_adr_i == `I2C_REG_DATA)
			txr <= wbs_dat_i;
		if (done)
			rxr <= rx_byte;
		if (acc) begin
			case (wbs_adr_i)
				`I2C_REG_PRE_LO: wbs_dat_o <= prescale[7:0];
				`I2C_REG_PRE_HI: wbs_dat_o <= prescale[15:8];
				`I2C_REG_CTRL:   wbs_dat_o <= {ena, 7'd0};
				`I2C_REG_DATA:   wbs_dat_o <= rxr;
				`I2C_REG_CMD:    wbs_dat_o <= stat; // Status on read
				default:         wbs_dat_o <= 8'h00;
			endcase
		end
	end

	i2c_byte_ctrl byte_ctrl0 (
		.clk         (clk),
		.nrst        (nrst),
		.ena_i       (ena),
		.prescale_i  (prescale),
		.go_i        (go),
		.cmd_i       (cmd_q),
		.tx_i        (txr),
		.rx_o        (rx_byte),
		.rxack_o     (rxack_b),
		.done_o      (done),
		.bus_busy_o  (bus_busy),
		.i2c_scl_i   (i2c_scl_i),
		.i2c_sda_i   (i2c_sda_i),
		.i2c_scl_t_o (i2c_scl_t_o),
		.i2c_sda_t_o (i2c_sda_t_o)
	);

endmodule

//--- src/i2c_byte_ctrl.sv
module i2c_byte_ctrl (
	input  logic               clk,
	input  logic               nrst,
	input  logic               ena_i,
	input  logic [15:0]        prescale_i,
	input  logic               go_i,
	input  i2c_pkg::cmd_bits_t cmd_i,
	input  logic [7:0]         tx_i,
	output logic [7:0]         rx_o,
	output logic               rxack_o,
	output logic               done_o,
	output logic               bus_busy_o,
	input  logic               i2c_scl_i,
	input  logic               i2c_sda_i,
	output logic               i2c_scl_t_o,
	output logic               i2c_sda_t_o
);

	typedef enum logic [2:0] {bs_idle, bs_start, bs_data, bs_ack, bs_stop} byte_state_t;

	byte_state_t        state;
	i2c_pkg::cmd_bits_t cmd_q;
	logic [7:0]         sr;       // Tx bits out, rx bits in
	logic [2:0]         bit_cnt;
	i2c_pkg::bit_cmd_t  bit_cmd;
	logic               bit_valid;
	logic               bit_din;
	logic               bit_ack;
	logic               bit_dout;

	assign rx_o = sr;

	// Shift register, MSB leaves first
	always_ff @(posedge clk) begin
		if (state == bs_idle && go_i)
			sr <= tx_i;
		else if (state == bs_data && bit_ack)
			sr <= {sr[6:0], bit_dout};
	end

	always_ff @(posedge clk) begin
		if (!nrst) begin
			state     <= bs_idle;
			cmd_q     <= '0;
			bit_cnt   <= 3'd0;
			bit_cmd   <= i2c_pkg::bc_none;
			bit_valid <= 1'b0;
			bit_din   <= 1'b1;
			done_o    <= 1'b0;
			rxack_o   <= 1'b0;
		end else begin
			bit_valid <= 1'b0; // Single-cycle request
			done_o    <= 1'b0;
			case (state)
				bs_idle: if (go_i) begin
					cmd_q     <= cmd_i;
					bit_cnt   <= 3'd7;
					bit_valid <= 1'b1;
					if (cmd_i.sta) begin
						state   <= bs_start;
						bit_cmd <= i2c_pkg::bc_start;
					end else if (cmd_i.rd || cmd_i.wr) begin
						state   <= bs_data;
						bit_cmd <= cmd_i.rd ? i2c_pkg::bc_read : i2c_pkg::bc_write;
						bit_din <= tx_i[7];
					end else begin
						state   <= bs_stop; // Lone STOP
						bit_cmd <= i2c_pkg::bc_stop;
					end
				end
				bs_start: if (bit_ack) begin
					state     <= bs_data;
					bit_valid <= 1'b1;
					bit_cmd   <= cmd_q.rd ? i2c_pkg::bc_read : i2c_pkg::bc_write;
					bit_din   <= sr[7];
				end
				bs_data: if (bit_ack) begin
					bit_valid <= 1'b1;
					if (bit_cnt == 3'd0) begin
						state   <= bs_ack;
						// Reads send cmd ack, writes listen for the slave
						bit_cmd <= cmd_q.rd ? i2c_pkg::bc_write : i2c_pkg::bc_read;
						bit_din <= cmd_q.ack;
					end else begin
						bit_cnt <= bit_cnt - 3'd1;
						bit_din <= sr[6]; // Next bit before the shift lands
					end
				end
				bs_ack: if (bit_ack) begin
					if (cmd_q.wr)
						rxack_o <= bit_dout;
					if (cmd_q.sto) begin
						state     <= bs_stop;
						bit_valid <= 1'b1;
						bit_cmd   <= i2c_pkg::bc_stop;
					end else begin
						state  <= bs_idle;
						done_o <= 1'b1;
					end
				end
				bs_stop: if (bit_ack) begin
					state  <= bs_idle;
					done_o <= 1'b1;
				end
				default: state <= bs_idle;
			endcase
		end
	end

	i2c_bit_ctrl bit_ctrl0 (
		.clk         (clk),
		.nrst        (nrst),
		.ena_i       (ena_i),
		.prescale_i  (prescale_i),
		.cmd_i       (bit_cmd),
		.cmd_valid_i (bit_valid),
		.din_i       (bit_din),
		.ack_o       (bit_ack),
		.dout_o      (bit_dout),
		.bus_busy_o  (bus_busy_o),
		.i2c_scl_i   (i2c_scl_i),
		.i2c_sda_i   (i2c_sda_i),
		.i2c_scl_t_o (i2c_scl_t_o),
		.i2c_sda_t_o (i2c_sda_t_o)
	);

endmodule

//--- src/i2c_bit_ctrl.sv
module i2c_bit_ctrl (
	input  logic              clk,
	input  logic              nrst,
	input  logic              ena_i,
	input  logic [15:0]       prescale_i,
	input  i2c_pkg::bit_cmd_t cmd_i,
	input  logic              cmd_valid_i,
	input  logic              din_i,
	output logic              ack_o,
	output logic              dout_o,
	output logic              bus_busy_o,
	input  logic              i2c_scl_i,
	input  logic              i2c_sda_i,
	output logic              i2c_scl_t_o,
	output logic              i2c_sda_t_o
);

	logic [1:0]        scl_sync; // Pin synchronizers
	logic [1:0]        sda_sync;
	logic              scl_s;
	logic              sda_s;
	logic              sda_d;    // Previous synced SDA for edge detect
	logic [15:0]       cnt;      // Quarter-phase counter
	logic              run;
	logic [1:0]        ph;       // Current quarter-phase
	i2c_pkg::bit_cmd_t cmd_q;
	logic              din_q;
	logic              stall;
	logic              tick;

	// Pin levels {scl, sda} per command and quarter-phase
	function automatic logic [1:0] wave(input i2c_pkg::bit_cmd_t c, input logic [1:0] p,
		input logic d, input logic [1:0] hold);
		logic [1:0] w;
		w = hold;
		case (c)
			i2c_pkg::bc_start: begin
				case (p)
					2'd0: w = {hold[1], 1'b1}; // SCL left where it was
					2'd1: w = 2'b11;
					2'd2: w = 2'b10;           // SDA falls with SCL high
					default: w = 2'b00;
				endcase
			end
			i2c_pkg::bc_stop: begin
				case (p)
					2'd0: w = 2'b00;
					2'd1: w = 2'b10;
					default: w = 2'b11;        // SDA rises with SCL high
				endcase
			end
			i2c_pkg::bc_write: w = {(p == 2'd1 || p == 2'd2), d};
			i2c_pkg::bc_read: w = {(p == 2'd1 || p == 2'd2), 1'b1}; // Release SDA
			default: w = hold;
		endcase
		return w;
	endfunction

	assign scl_s = scl_sync[1];
	assign sda_s = sda_sync[1];

	// Slave holds SCL low although we released it
	assign stall = i2c_scl_t_o & ~scl_s;
	assign tick  = run & ~stall & (cnt == 16'd0);

	always_ff @(posedge clk) begin
		if (!nrst) begin
			scl_sync   <= 2'b11;
			sda_sync   <= 2'b11;
			sda_d      <= 1'b1;
			bus_busy_o <= 1'b0;
		end else begin
			scl_sync <= {scl_sync[0], i2c_scl_i};
			sda_sync <= {sda_sync[0], i2c_sda_i};
			sda_d    <= sda_s;
			if (scl_s && sda_d && !sda_s)      // START seen
				bus_busy_o <= 1'b1;
			else if (scl_s && !sda_d && sda_s) // STOP seen
				bus_busy_o <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (!nrst)
			cnt <= 16'd0;
		else if (!run)
			cnt <= prescale_i; // Preload for the next command
		else if (!stall)
			cnt <= (cnt == 16'd0) ? prescale_i : cnt - 16'd1;
	end

	always_ff @(posedge clk) begin
		if (!nrst) begin
			run         <= 1'b0;
			ph          <= 2'd0;
			cmd_q       <= i2c_pkg::bc_none;
			din_q       <= 1'b1;
			ack_o       <= 1'b0;
			dout_o      <= 1'b0;
			i2c_scl_t_o <= 1'b1;
			i2c_sda_t_o <= 1'b1;
		end else begin
			ack_o <= 1'b0;
			if (!run) begin
				if (cmd_valid_i && ena_i && cmd_i != i2c_pkg::bc_none) begin
					run   <= 1'b1;
					ph    <= 2'd0;
					cmd_q <= cmd_i;
					din_q <= din_i;
					{i2c_scl_t_o, i2c_sda_t_o} <= wave(cmd_i, 2'd0, din_i,
						{i2c_scl_t_o, i2c_sda_t_o});
				end
			end else if (tick) begin
				if (ph == 2'd2)
					dout_o <= sda_s; // Sample at end of SCL high
				if (ph == 2'd3) begin
					run   <= 1'b0;
					ack_o <= 1'b1;
				end else begin
					ph <= ph + 2'd1;
					{i2c_scl_t_o, i2c_sda_t_o} <= wave(cmd_q, ph + 2'd1, din_q,
						{i2c_scl_t_o, i2c_sda_t_o});
				end
			end
		end
	end

endmodule

//--- src/i2c_pkg.sv
package i2c_pkg;

	// Single-bit bus operations, byte ctrl to bit ctrl
	typedef enum logic [2:0] {
		bc_none,
		bc_start,
		bc_stop,
		bc_write,
		bc_read
	} bit_cmd_t;

	// Command register layout, MSB first
	typedef struct packed {
		logic       sta; // Generate START
		logic       sto; // Generate STOP after the byte
		logic       rd;  // Read a byte
		logic       wr;  // Write a byte
		logic       ack; // Ack level to send on reads, 1 is NACK
		logic [2:0] pad;
	} cmd_bits_t;

	// Status register layout
	typedef struct packed {
		logic       rxack;  // 1 means slave did not acknowledge
		logic       busy;   // Between START and STOP on the pins
		logic [3:0] pad_hi;
		logic       tip;    // Byte transfer running
		logic       pad_lo;
	} stat_bits_t;

	// Host-side sequencer states
	typedef enum logic [3:0] {
		cs_init_plo, cs_init_phi, cs_init_ctrl, // Core setup after reset
		cs_idle,
		cs_addr_tx, cs_addr_cmd, cs_addr_poll,  // Address phase
		cs_wr_tx, cs_wr_cmd,                    // Write data byte
		cs_rd_cmd, cs_rd_data,                  // Read data byte
		cs_data_poll,
		cs_nack_stop, cs_nack_poll              // Abort after address NACK
	} ctrl_state_t;

endpackage

//--- src/i2c_config.svh
`ifndef I2C_CONFIG_SVH
`define I2C_CONFIG_SVH

// One SCL quarter-phase lasts prescale+1 clocks
`define I2C_PRESCALE 16'd4

// Register map of the 8-bit master core
`define I2C_REG_PRE_LO 3'd0 // Prescale low byte
`define I2C_REG_PRE_HI 3'd1 // Prescale high byte
`define I2C_REG_CTRL   3'd2 // Bit 7 is core enable
`define I2C_REG_DATA   3'd3 // Write tx byte, read rx byte
`define I2C_REG_CMD    3'd4 // Write command, read status

// Simulation run limit in clock cycles
// 40 transactions at roughly 600 cycles, plus margin
`define I2C_TIMEOUT_CYCLES 30000

`endif
